// File: rtl/streamer_pkg.sv
//////////////////////////////////////////////////////////////////////
// Streamer package
// Widths, channel ids, buffer depths and the structs shared by the
// load/store streamer and its Wishbone memory port
//////////////////////////////////////////////////////////////////////

package streamer_pkg;

  // Memory and stream word geometry
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned SEL_W  = DATA_W / 8;

  // Channel ids, also the bit order of the arbiter request vectors
  localparam int unsigned NUM_CHAN  = 4;
  localparam int unsigned X_CHAN_ID = 0;
  localparam int unsigned W_CHAN_ID = 1;
  localparam int unsigned Y_CHAN_ID = 2;
  localparam int unsigned Z_CHAN_ID = 3;

  // Job length and per-channel buffering
  localparam int unsigned LEN_W            = 16;
  localparam int unsigned LOAD_FIFO_DEPTH  = 4;
  localparam int unsigned STORE_FIFO_DEPTH = 2;

  // One channel job, stride is in bytes and len in words
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [LEN_W-1:0]  len;
  } stream_cfg_t;

  typedef struct packed {
    stream_cfg_t x;
    stream_cfg_t w;
    stream_cfg_t y;
    stream_cfg_t z;
  } streamer_ctrl_t;

  // Sticky completion bits and the global busy
  typedef struct packed {
    logic done_x;
    logic done_w;
    logic done_y;
    logic done_z;
    logic busy;
  } streamer_flags_t;

  // Request from a channel towards the arbiter
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  sel;
  } mem_req_t;

  // Wishbone classic master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_m2s_t;

  // Wishbone classic slave to master
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_s2m_t;

endpackage

// File: rtl/stream_fifo.sv
//////////////////////////////////////////////////////////////////////
// Stream FIFO
// Synchronous circular buffer with a type parameter for its payload
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_fifo #(
  parameter  int unsigned DEPTH = 4,
  parameter  type         T     = logic [streamer_pkg::DATA_W-1:0],
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clear_i,
  input  logic             push_i,
  input  T                 data_i,
  output logic             full_o,
  output logic [CNT_W-1:0] count_o,
  input  logic             pop_i,
  output T                 data_o,
  output logic             empty_o
);

  // A depth of one still needs a one bit pointer
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  // Pointer increment with wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      // A new job drops whatever is left
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Occupancy only moves when exactly one side is active
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign count_o = cnt_q;
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);

  // The producer must pace itself on full_o
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

  // The consumer only pops a word it has seen
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

// File: rtl/stream_addr_gen.sv
//////////////////////////////////////////////////////////////////////
// Strided address generator
// Walks base + i*stride for len words of one channel job
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_addr_gen (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              start_i,
  input  streamer_pkg::stream_cfg_t         cfg_i,
  input  logic                              step_i,
  output logic [streamer_pkg::ADDR_W-1:0]   addr_o,
  output logic                              last_o,
  output logic                              done_o
);

  logic [streamer_pkg::ADDR_W-1:0] addr_q;
  logic [streamer_pkg::ADDR_W-1:0] stride_q;
  logic [streamer_pkg::LEN_W-1:0]  left_q;
  logic                            done_q;

  // Remaining words and the completion flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      left_q <= '0;
      done_q <= 1'b0;
    end else if (start_i) begin
      left_q <= cfg_i.len;
      // An empty job is finished right away
      done_q <= (cfg_i.len == '0);
    end else if (step_i) begin
      left_q <= left_q - 1'b1;
      done_q <= last_o;
    end
  end

  // Address walk
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= cfg_i.base;
      stride_q <= cfg_i.stride;
    end else if (step_i) begin
      addr_q <= addr_q + stride_q;
    end
  end

  assign addr_o = addr_q;
  // Final address flagged in the same cycle it is presented
  assign last_o = (left_q == streamer_pkg::LEN_W'(1));
  assign done_o = done_q;

  // The owning channel stops stepping once the job is complete
  a_no_step_done : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    step_i |-> !done_o);

endmodule

// File: rtl/stream_source.sv
//////////////////////////////////////////////////////////////////////
// Load channel
// Issues strided reads and turns the returned words into a
// valid/ready stream through a small FIFO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_source (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              start_i,
  input  streamer_pkg::stream_cfg_t         cfg_i,
  output logic                              req_valid_o,
  output streamer_pkg::mem_req_t            req_o,
  input  logic                              gnt_done_i,
  input  logic [streamer_pkg::DATA_W-1:0]   rdata_i,
  output logic                              valid_o,
  output logic [streamer_pkg::DATA_W-1:0]   data_o,
  input  logic                              ready_i,
  output logic                              done_o
);

  logic [streamer_pkg::ADDR_W-1:0]                    rd_addr;
  logic                                               gen_done;
  logic [$clog2(streamer_pkg::LOAD_FIFO_DEPTH+1)-1:0] fifo_cnt;
  logic                                               fifo_empty;
  logic                                               active_q;
  logic                                               done_q;

  // Address steps when the read in flight is acknowledged
  stream_addr_gen i_addr_gen (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .start_i ( start_i    ),
    .cfg_i   ( cfg_i      ),
    .step_i  ( gnt_done_i ),
    .addr_o  ( rd_addr    ),
    .last_o  (            ),
    .done_o  ( gen_done   )
  );

  // Returned words land here on the ack edge
  stream_fifo #(
    .DEPTH ( streamer_pkg::LOAD_FIFO_DEPTH          ),
    .T     ( logic [streamer_pkg::DATA_W-1:0]       )
  ) i_load_fifo (
    .clk_i   ( clk_i               ),
    .rst_n_i ( rst_n_i             ),
    .clear_i ( start_i             ),
    .push_i  ( gnt_done_i          ),
    .data_i  ( rdata_i             ),
    .full_o  (                     ),
    .count_o ( fifo_cnt            ),
    .pop_i   ( valid_o && ready_i  ),
    .data_o  ( data_o              ),
    .empty_o ( fifo_empty          )
  );

  // The request stays up until its ack, so it is the outstanding read
  // Issuing only below depth keeps a free slot reserved for it
  assign req_valid_o = active_q && !gen_done &&
                       (fifo_cnt < streamer_pkg::LOAD_FIFO_DEPTH);
  assign req_o       = '{addr: rd_addr, we: 1'b0, wdata: '0, sel: '1};

  assign valid_o = !fifo_empty;

  // Job tracking, done once every word has left the FIFO
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (start_i) begin
      active_q <= 1'b1;
      done_q   <= 1'b0;
    end else if (active_q && gen_done && fifo_empty) begin
      active_q <= 1'b0;
      done_q   <= 1'b1;
    end
  end

  assign done_o = done_q;

endmodule

// File: rtl/stream_sink.sv
//////////////////////////////////////////////////////////////////////
// Store channel
// Pairs incoming stream words with strided addresses and queues
// them as write requests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_sink (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              start_i,
  input  streamer_pkg::stream_cfg_t         cfg_i,
  input  logic                              valid_i,
  input  logic [streamer_pkg::DATA_W-1:0]   data_i,
  output logic                              ready_o,
  output logic                              req_valid_o,
  output streamer_pkg::mem_req_t            req_o,
  input  logic                              gnt_done_i,
  output logic                              done_o
);

  logic [streamer_pkg::ADDR_W-1:0] wr_addr;
  logic                            gen_done;
  logic                            fifo_full;
  logic                            fifo_empty;
  logic                            accept;
  streamer_pkg::mem_req_t          wr_req;
  logic                            active_q;
  logic                            done_q;

  // Accept while there is room and the job still wants words
  assign ready_o = active_q && !gen_done && !fifo_full;
  assign accept  = valid_i && ready_o;

  // Each accepted word takes the next address
  stream_addr_gen i_addr_gen (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .start_i ( start_i  ),
    .cfg_i   ( cfg_i    ),
    .step_i  ( accept   ),
    .addr_o  ( wr_addr  ),
    .last_o  (          ),
    .done_o  ( gen_done )
  );

  // Full word write, all byte lanes enabled
  assign wr_req = '{addr: wr_addr, we: 1'b1, wdata: data_i, sel: '1};

  stream_fifo #(
    .DEPTH ( streamer_pkg::STORE_FIFO_DEPTH ),
    .T     ( streamer_pkg::mem_req_t        )
  ) i_store_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .clear_i ( start_i    ),
    .push_i  ( accept     ),
    .data_i  ( wr_req     ),
    .full_o  ( fifo_full  ),
    .count_o (            ),
    .pop_i   ( gnt_done_i ),
    .data_o  ( req_o      ),
    .empty_o ( fifo_empty )
  );

  // Head of the FIFO is the pending write
  assign req_valid_o = !fifo_empty;

  // Done when all words are taken and the last write is acked
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (start_i) begin
      active_q <= 1'b1;
      done_q   <= 1'b0;
    end else if (active_q && gen_done && fifo_empty) begin
      active_q <= 1'b0;
      done_q   <= 1'b1;
    end
  end

  assign done_o = done_q;

endmodule

// File: rtl/ldst_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Load/store arbiter and Wishbone classic master
// Round robin over X, W and the shared Y/Z slot, with Z ahead of Y,
// one transaction in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ldst_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [streamer_pkg::NUM_CHAN-1:0]                 req_valid_i,
  input  streamer_pkg::mem_req_t [streamer_pkg::NUM_CHAN-1:0] req_i,
  output logic [streamer_pkg::NUM_CHAN-1:0]                 gnt_done_o,
  output logic [streamer_pkg::DATA_W-1:0]                   rdata_o,
  output streamer_pkg::wb_m2s_t                             wb_o,
  input  streamer_pkg::wb_s2m_t                             wb_i
);

  // Y and Z share one slot, so there is one slot fewer than channels
  localparam int unsigned NUM_SLOT = streamer_pkg::NUM_CHAN - 1;
  localparam int unsigned SLOT_W   = $clog2(NUM_SLOT);
  localparam int unsigned CHAN_W   = $clog2(streamer_pkg::NUM_CHAN);

  logic [NUM_SLOT-1:0]   slot_req;
  logic [SLOT_W-1:0]     rr_q;
  logic [SLOT_W-1:0]     win_slot;
  logic                  win_vld;
  logic [CHAN_W-1:0]     win_chan;
  logic [CHAN_W-1:0]     gnt_q;
  streamer_pkg::wb_m2s_t wb_q;

  // Slot index equals the channel id for X, W and Y
  assign slot_req[streamer_pkg::X_CHAN_ID] = req_valid_i[streamer_pkg::X_CHAN_ID];
  assign slot_req[streamer_pkg::W_CHAN_ID] = req_valid_i[streamer_pkg::W_CHAN_ID];
  assign slot_req[streamer_pkg::Y_CHAN_ID] = req_valid_i[streamer_pkg::Y_CHAN_ID] |
                                             req_valid_i[streamer_pkg::Z_CHAN_ID];

  // Round robin pick starting at rr_q
  always_comb begin
    int unsigned slot;
    win_vld  = 1'b0;
    win_slot = rr_q;
    // Scan far to near so the slot closest to the pointer wins
    for (int k = NUM_SLOT - 1; k >= 0; k--) begin
      slot = (int'(rr_q) + k) % NUM_SLOT;
      if (slot_req[slot]) begin
        win_vld  = 1'b1;
        win_slot = SLOT_W'(slot);
      end
    end
  end

  // A pending store takes the Y/Z slot ahead of the Y load
  always_comb begin
    win_chan = CHAN_W'(win_slot);
    if (win_slot == SLOT_W'(streamer_pkg::Y_CHAN_ID) &&
        req_valid_i[streamer_pkg::Z_CHAN_ID]) begin
      win_chan = CHAN_W'(streamer_pkg::Z_CHAN_ID);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_q.cyc <= 1'b0;
      wb_q.stb <= 1'b0;
      rr_q     <= '0;
    end else if (wb_q.cyc) begin
      // Bus frozen until the slave acks, then one idle cycle
      if (wb_i.ack) begin
        wb_q.cyc <= 1'b0;
        wb_q.stb <= 1'b0;
      end
    end else if (win_vld) begin
      wb_q.cyc <= 1'b1;
      wb_q.stb <= 1'b1;
      wb_q.we  <= req_i[win_chan].we;
      wb_q.adr <= req_i[win_chan].addr;
      wb_q.dat <= req_i[win_chan].wdata;
      wb_q.sel <= req_i[win_chan].sel;
      gnt_q    <= win_chan;
      // Next turn goes to the slot after the winner
      rr_q     <= (win_slot == SLOT_W'(NUM_SLOT - 1)) ? '0 : win_slot + 1'b1;
    end
  end

  // One-hot completion pulse in the ack cycle
  always_comb begin
    gnt_done_o        = '0;
    gnt_done_o[gnt_q] = wb_q.cyc & wb_i.ack;
  end

  assign rdata_o = wb_i.dat;
  assign wb_o    = wb_q;

  // The granted channel keeps presenting the latched request until its ack
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.cyc |-> req_valid_i[gnt_q] && req_i[gnt_q].addr == wb_o.adr &&
                 req_i[gnt_q].we == wb_o.we && req_i[gnt_q].wdata == wb_o.dat);

  // Address held across wait states
  a_adr_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.stb && !wb_i.ack |=> $stable(wb_o.adr));

endmodule

// File: rtl/redmule_streamer.sv
//////////////////////////////////////////////////////////////////////
// Streamer top level
// Three load channels and one store channel sharing a single
// Wishbone classic master port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module redmule_streamer (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              start_i,
  input  streamer_pkg::streamer_ctrl_t      ctrl_i,
  output streamer_pkg::streamer_flags_t     flags_o,
  // X load stream
  output logic                              x_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]   x_data_o,
  input  logic                              x_ready_i,
  // W load stream
  output logic                              w_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]   w_data_o,
  input  logic                              w_ready_i,
  // Y load stream
  output logic                              y_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]   y_data_o,
  input  logic                              y_ready_i,
  // Z store stream
  input  logic                              z_valid_i,
  input  logic [streamer_pkg::DATA_W-1:0]   z_data_i,
  output logic                              z_ready_o,
  // Memory port
  output streamer_pkg::wb_m2s_t             wb_o,
  input  streamer_pkg::wb_s2m_t             wb_i
);

  logic [streamer_pkg::NUM_CHAN-1:0]                   req_valid;
  streamer_pkg::mem_req_t [streamer_pkg::NUM_CHAN-1:0] req;
  logic [streamer_pkg::NUM_CHAN-1:0]                   gnt_done;
  logic [streamer_pkg::NUM_CHAN-1:0]                   done;
  logic [streamer_pkg::DATA_W-1:0]                     rdata;
  logic                                                busy_q;

  stream_source i_x_source (
    .clk_i       ( clk_i                                ),
    .rst_n_i     ( rst_n_i                              ),
    .start_i     ( start_i                              ),
    .cfg_i       ( ctrl_i.x                             ),
    .req_valid_o ( req_valid[streamer_pkg::X_CHAN_ID]   ),
    .req_o       ( req[streamer_pkg::X_CHAN_ID]         ),
    .gnt_done_i  ( gnt_done[streamer_pkg::X_CHAN_ID]    ),
    .rdata_i     ( rdata                                ),
    .valid_o     ( x_valid_o                            ),
    .data_o      ( x_data_o                             ),
    .ready_i     ( x_ready_i                            ),
    .done_o      ( done[streamer_pkg::X_CHAN_ID]        )
  );

  stream_source i_w_source (
    .clk_i       ( clk_i                                ),
    .rst_n_i     ( rst_n_i                              ),
    .start_i     ( start_i                              ),
    .cfg_i       ( ctrl_i.w                             ),
    .req_valid_o ( req_valid[streamer_pkg::W_CHAN_ID]   ),
    .req_o       ( req[streamer_pkg::W_CHAN_ID]         ),
    .gnt_done_i  ( gnt_done[streamer_pkg::W_CHAN_ID]    ),
    .rdata_i     ( rdata                                ),
    .valid_o     ( w_valid_o                            ),
    .data_o      ( w_data_o                             ),
    .ready_i     ( w_ready_i                            ),
    .done_o      ( done[streamer_pkg::W_CHAN_ID]        )
  );

  stream_source i_y_source (
    .clk_i       ( clk_i                                ),
    .rst_n_i     ( rst_n_i                              ),
    .start_i     ( start_i                              ),
    .cfg_i       ( ctrl_i.y                             ),
    .req_valid_o ( req_valid[streamer_pkg::Y_CHAN_ID]   ),
    .req_o       ( req[streamer_pkg::Y_CHAN_ID]         ),
    .gnt_done_i  ( gnt_done[streamer_pkg::Y_CHAN_ID]    ),
    .rdata_i     ( rdata                                ),
    .valid_o     ( y_valid_o                            ),
    .data_o      ( y_data_o                             ),
    .ready_i     ( y_ready_i                            ),
    .done_o      ( done[streamer_pkg::Y_CHAN_ID]        )
  );

  stream_sink i_z_sink (
    .clk_i       ( clk_i                                ),
    .rst_n_i     ( rst_n_i                              ),
    .start_i     ( start_i                              ),
    .cfg_i       ( ctrl_i.z                             ),
    .valid_i     ( z_valid_i                            ),
    .data_i      ( z_data_i                             ),
    .ready_o     ( z_ready_o                            ),
    .req_valid_o ( req_valid[streamer_pkg::Z_CHAN_ID]   ),
    .req_o       ( req[streamer_pkg::Z_CHAN_ID]         ),
    .gnt_done_i  ( gnt_done[streamer_pkg::Z_CHAN_ID]    ),
    .done_o      ( done[streamer_pkg::Z_CHAN_ID]        )
  );

  ldst_arbiter i_ldst_arbiter (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_valid_i ( req_valid ),
    .req_i       ( req       ),
    .gnt_done_o  ( gnt_done  ),
    .rdata_o     ( rdata     ),
    .wb_o        ( wb_o      ),
    .wb_i        ( wb_i      )
  );

  // Job in progress since the last start
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
    end else if (&done) begin
      busy_q <= 1'b0;
    end
  end

  // Busy drops as soon as the last channel reports done
  assign flags_o = '{
    done_x: done[streamer_pkg::X_CHAN_ID],
    done_w: done[streamer_pkg::W_CHAN_ID],
    done_y: done[streamer_pkg::Y_CHAN_ID],
    done_z: done[streamer_pkg::Z_CHAN_ID],
    busy:   busy_q && !(&done)
  };

endmodule

// File: test/tb_mem_model.sv
//////////////////////////////////////////////////////////////////////
// Wishbone memory model
// Classic slave with random wait states and a backdoor word array
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mem_model #(
  parameter int unsigned WORDS = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  streamer_pkg::wb_m2s_t wb_i,
  output streamer_pkg::wb_s2m_t wb_o
);

  localparam int unsigned IDX_W = $clog2(WORDS);

  // Backdoor array, preloaded and read back by the testbench
  logic [streamer_pkg::DATA_W-1:0] mem_q [WORDS];
  logic [streamer_pkg::DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]                idx;
  logic [1:0]                      wait_q;
  logic                            pend_q;
  logic                            ack_q;

  // Word index from the byte address
  assign idx = wb_i.adr[IDX_W+1:2];

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      pend_q  <= 1'b0;
      wait_q  <= '0;
      rdata_q <= '0;
    end else begin
      ack_q <= 1'b0;
      // Ack cycle is skipped so each request completes once
      if (wb_i.cyc && wb_i.stb && !ack_q) begin
        if (!pend_q) begin
          // 0 to 3 extra cycles on top of the registered ack
          pend_q <= 1'b1;
          wait_q <= 2'($urandom_range(3, 0));
        end else if (wait_q != '0) begin
          wait_q <= wait_q - 1'b1;
        end else begin
          pend_q <= 1'b0;
          ack_q  <= 1'b1;
          if (wb_i.we) begin
            mem_q[idx] = wb_i.dat;
          end else begin
            rdata_q <= mem_q[idx];
          end
        end
      end
    end
  end

  assign wb_o = '{ack: ack_q, dat: rdata_q};

endmodule

// File: test/tb_streamer.sv
//////////////////////////////////////////////////////////////////////
// Streamer testbench
// Two jobs on all four channels against a Wishbone memory model,
// with random stream back-pressure and memory wait states
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_streamer;

  localparam int unsigned SEED      = 32'h974;
  localparam int unsigned MEM_WORDS = 1024;

  // DUT ports
  logic                            clk_i;
  logic                            rst_n_i;
  logic                            start_i;
  streamer_pkg::streamer_ctrl_t    ctrl_i;
  streamer_pkg::streamer_flags_t   flags_o;
  logic                            x_valid_o;
  logic [streamer_pkg::DATA_W-1:0] x_data_o;
  logic                            x_ready_i;
  logic                            w_valid_o;
  logic [streamer_pkg::DATA_W-1:0] w_data_o;
  logic                            w_ready_i;
  logic                            y_valid_o;
  logic [streamer_pkg::DATA_W-1:0] y_data_o;
  logic                            y_ready_i;
  logic                            z_valid_i;
  logic [streamer_pkg::DATA_W-1:0] z_data_i;
  logic                            z_ready_o;
  streamer_pkg::wb_m2s_t           wb_o;
  streamer_pkg::wb_s2m_t           wb_i;

  // Scoreboard state kept by the negedge monitor
  streamer_pkg::streamer_ctrl_t    cur;
  int unsigned                     x_cnt;
  int unsigned                     w_cnt;
  int unsigned                     y_cnt;
  int unsigned                     z_cnt;
  logic                            z_fire;
  logic                            running;
  logic [streamer_pkg::DATA_W-1:0] exp_mem [MEM_WORDS];
  int unsigned                     cycles;
  int unsigned                     cycle_limit;
  // Bus history for the protocol checks
  logic                            bus_wait;
  logic                            bus_ack;
  streamer_pkg::wb_m2s_t           bus_prev;

  redmule_streamer dut_i (.*);

  tb_mem_model #(.WORDS(MEM_WORDS)) i_mem (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .wb_i    ( wb_o    ),
    .wb_o    ( wb_i    )
  );

  // Preload value is the word index of the byte address XOR a tag
  function automatic logic [31:0] preload_value(input logic [31:0] addr);
    return (addr >> 2) ^ 32'h5A5A0000;
  endfunction

  function automatic streamer_pkg::stream_cfg_t job_cfg(input logic [31:0] base,
      input logic [31:0] stride, input logic [15:0] len);
    return '{base: base, stride: stride, len: len};
  endfunction

  function automatic int unsigned job_words(input streamer_pkg::streamer_ctrl_t job);
    return job.x.len + job.w.len + job.y.len + job.z.len;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // Word i of a load job comes from base + i*stride
  task automatic check_load(input string name, input logic [31:0] data,
                            input streamer_pkg::stream_cfg_t cfg, inout int unsigned cnt);
    logic [31:0] exp;
    exp = preload_value(cfg.base + cnt * cfg.stride);
    assert (cnt < cfg.len) else begin
      $display("The %s stream delivered more than %0d words", name, cfg.len);
      stop_with_failure();
    end
    assert (data == exp) else begin
      $display("CHECK FAILED %s word %0d got %08h expected %08h", name, cnt, data, exp);
      stop_with_failure();
    end
    cnt++;
  endtask

  // Z word i lands at base + i*stride in the expected image
  task automatic record_store();
    int unsigned idx;
    assert (z_cnt < cur.z.len) else begin
      $display("The Z stream accepted more than %0d words", cur.z.len);
      stop_with_failure();
    end
    idx = ((cur.z.base + z_cnt * cur.z.stride) >> 2) % MEM_WORDS;
    exp_mem[idx] = z_data_i;
    z_cnt++;
  endtask

  task automatic check_idle();
    assert (flags_o == '0) else begin
      $display("CHECK FAILED flags_o got %02h expected 00", flags_o);
      stop_with_failure();
    end
    assert (!x_valid_o && !w_valid_o && !y_valid_o && !z_ready_o && !wb_o.cyc) else begin
      $display("A stream or the memory bus became active before the first start");
      stop_with_failure();
    end
  endtask

  task automatic check_flags();
    logic all_done;
    all_done = flags_o.done_x && flags_o.done_w && flags_o.done_y && flags_o.done_z;
    assert (flags_o.busy == !all_done) else begin
      $display("CHECK FAILED busy got %h expected %h", flags_o.busy, !all_done);
      stop_with_failure();
    end
    assert ((!flags_o.done_x || x_cnt == cur.x.len) && (!flags_o.done_w || w_cnt == cur.w.len)
         && (!flags_o.done_y || y_cnt == cur.y.len) && (!flags_o.done_z || z_cnt == cur.z.len))
    else begin
      $display("A done flag rose before its channel moved every word of the job");
      stop_with_failure();
    end
  endtask

  task automatic check_memory();
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      assert (i_mem.mem_q[i] == exp_mem[i]) else begin
        $display("CHECK FAILED mem_q[%0d] got %08h expected %08h",
                 i, i_mem.mem_q[i], exp_mem[i]);
        stop_with_failure();
      end
    end
  endtask

  task automatic run_job(input streamer_pkg::streamer_ctrl_t job);
    @(posedge clk_i);
    #1;
    ctrl_i  = job;
    start_i = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    // Watchdog bounds this wait
    do begin
      @(negedge clk_i);
    end while (!(flags_o.done_x && flags_o.done_w && flags_o.done_y && flags_o.done_z));
    // Word counts are final once every channel is done
    check_flags();
    check_memory();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Cycle watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout, the jobs did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  // Random back-pressure and Z words driven just after the edge
  always @(posedge clk_i) begin
    #1;
    x_ready_i = ($urandom_range(3, 0) != 0);
    w_ready_i = ($urandom_range(1, 0) != 0);
    y_ready_i = ($urandom_range(3, 0) != 0);
    // A presented Z word holds until taken
    if (!z_valid_i || z_fire) begin
      // Words keep coming past the job length to expose over-acceptance
      if ($urandom_range(3, 0) != 0) begin
        z_valid_i = 1'b1;
        z_data_i  = $urandom;
      end else begin
        z_valid_i = 1'b0;
      end
    end
  end

  // Handshakes sampled mid-cycle while inputs and outputs are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      z_fire = z_valid_i && z_ready_o;
      if (start_i) begin
        // New job is captured on the coming edge
        cur     = ctrl_i;
        x_cnt   = 0;
        w_cnt   = 0;
        y_cnt   = 0;
        z_cnt   = 0;
        running = 1'b1;
      end else if (!running) begin
        check_idle();
      end else begin
        check_flags();
        if (x_valid_o && x_ready_i) check_load("x_data_o", x_data_o, cur.x, x_cnt);
        if (w_valid_o && w_ready_i) check_load("w_data_o", w_data_o, cur.w, w_cnt);
        if (y_valid_o && y_ready_i) check_load("y_data_o", y_data_o, cur.y, y_cnt);
        if (z_fire) record_store();
      end
    end
  end

  // Wishbone classic protocol at the DUT port
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      assert (wb_o.stb == wb_o.cyc) else begin
        $display("CHECK FAILED wb_o.stb got %h expected %h", wb_o.stb, wb_o.cyc);
        stop_with_failure();
      end
      assert (!wb_o.stb || wb_o.sel == '1) else begin
        $display("CHECK FAILED wb_o.sel got %h expected f", wb_o.sel);
        stop_with_failure();
      end
      assert (!bus_wait || (wb_o.stb && wb_o.we == bus_prev.we &&
              wb_o.adr == bus_prev.adr && wb_o.dat == bus_prev.dat)) else begin
        $display("CHECK FAILED wb_o changed before ack, adr %08h to %08h, dat %08h to %08h",
                 bus_prev.adr, wb_o.adr, bus_prev.dat, wb_o.dat);
        stop_with_failure();
      end
      assert (!bus_ack || !wb_o.cyc) else begin
        $display("The master kept cyc high in the cycle after an ack");
        stop_with_failure();
      end
      bus_wait = wb_o.stb && !wb_i.ack;
      bus_ack  = wb_o.stb && wb_i.ack;
      bus_prev = wb_o;
    end
  end

  initial begin
    streamer_pkg::streamer_ctrl_t job_a;
    streamer_pkg::streamer_ctrl_t job_b;
    void'($urandom(SEED));
    rst_n_i   = 1'b0;
    start_i   = 1'b0;
    ctrl_i    = '0;
    x_ready_i = 1'b0;
    w_ready_i = 1'b0;
    y_ready_i = 1'b0;
    z_valid_i = 1'b0;
    z_data_i  = '0;
    cur       = '0;
    x_cnt     = 0;
    w_cnt     = 0;
    y_cnt     = 0;
    z_cnt     = 0;
    z_fire    = 1'b0;
    running   = 1'b0;
    bus_wait  = 1'b0;
    bus_ack   = 1'b0;
    bus_prev  = '0;
    cycles    = 0;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      i_mem.mem_q[i] = preload_value(i * 4);
      exp_mem[i]     = preload_value(i * 4);
    end
    // Load regions never overlap a store region of either job
    job_a.x = job_cfg(32'h0000_0000, 32'd4, 16'd12);
    job_a.w = job_cfg(32'h0000_0200, 32'd8, 16'd10);
    job_a.y = job_cfg(32'h0000_0400, 32'd12, 16'd8);
    job_a.z = job_cfg(32'h0000_0800, 32'd4, 16'd10);
    job_b.x = job_cfg(32'h0000_0100, 32'd16, 16'd6);
    job_b.w = job_cfg(32'h0000_0300, 32'd4, 16'd9);
    job_b.y = job_cfg(32'h0000_0600, 32'd8, 16'd7);
    job_b.z = job_cfg(32'h0000_0A00, 32'd8, 16'd8);
    cycle_limit = 20 * (job_words(job_a) + job_words(job_b)) + 1000;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // Idle window before the first start
    repeat (4) @(posedge clk_i);
    run_job(job_a);
    run_job(job_b);
    $display("TEST OK");
    $finish;
  end

endmodule

// File: streamer.f
rtl/streamer_pkg.sv
rtl/stream_fifo.sv
rtl/stream_addr_gen.sv
rtl/stream_source.sv
rtl/stream_sink.sv
rtl/ldst_arbiter.sv
rtl/redmule_streamer.sv
test/tb_mem_model.sv
test/tb_streamer.sv

// File: Makefile
TOP := tb_streamer

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): streamer.f $(wildcard rtl/*.sv test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f streamer.f

lint:
	verilator --lint-only --top-module redmule_streamer $(shell grep '^rtl/' streamer.f)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
